/* logic/frame_writer_params.svh */
`ifndef FRAME_WRITER_PARAMS_SVH
`define FRAME_WRITER_PARAMS_SVH

// bus widths
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 64

// one burst is a fixed run of full-width beats
`define BURST_LEN   16
`define BURST_BYTES (`BURST_LEN * (`AXI_DATA_WIDTH / 8))

// frame geometry
`define IMAGE_W     32
`define IMAGE_H     4
`define PIXEL_BYTES 4
`define FRAME_BYTES (`IMAGE_W * `IMAGE_H * `PIXEL_BYTES)

`define BURSTS_PER_FRAME (`FRAME_BYTES / `BURST_BYTES)

`define BUF_NUM      3                // frame buffers in rotation
`define WR_BASE_ADDR 32'h0200_0000    // start of buffer 0

`define FIFO_DEPTH 64                 // at least one burst

`endif

/* logic/frame_writer_pkg.sv */
`include "frame_writer_params.svh"

package frame_writer_pkg;

    typedef logic [`AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [`AXI_DATA_WIDTH-1:0] axi_data_t;

    typedef logic [$clog2(`BURST_LEN)-1:0]        beat_cnt_t;   // beat within a burst
    typedef logic [$clog2(`BURSTS_PER_FRAME)-1:0] burst_cnt_t;  // burst within a frame
    typedef logic [$clog2(`BUF_NUM)-1:0]          buf_index_t;
    typedef logic [$clog2(`FIFO_DEPTH+1)-1:0]     fifo_cnt_t;   // 0 up to FIFO_DEPTH

    // scheduler to master
    typedef struct packed {
        axi_addr_t addr;
    } burst_req_t;

    // AW channel payload, the fixed sideband fields are implied
    typedef struct packed {
        axi_addr_t addr;
    } aw_req_t;

    // W channel payload
    typedef struct packed {
        axi_data_t data;
        logic      last;
    } w_beat_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA
    } wr_state_e;

endpackage

/* logic/pixel_fifo.sv */
`timescale 1ns/1ns
`include "frame_writer_params.svh"

module pixel_fifo
    import frame_writer_pkg::*;
(
    input  logic      M_AXI_ACLK,
    input  logic      sync_axi_rst,
    input  axi_data_t pix_data,
    input  logic      pix_valid,
    output logic      pix_ready,
    output axi_data_t head,
    input  logic      pop,
    output fifo_cnt_t count
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    axi_data_t        mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    fifo_cnt_t        fill;
    logic             push;
    logic             take;

    // pointer step with explicit wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign pix_ready = (fill != fifo_cnt_t'(`FIFO_DEPTH));
    assign push      = pix_valid & pix_ready;
    assign take      = pop & (fill != '0);   // never pop an empty fifo

    assign head  = mem[rd_ptr];  // first word falls through
    assign count = fill;

    always_ff @(posedge M_AXI_ACLK) begin
        if (push) begin
            mem[wr_ptr] <= pix_data;
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (!sync_axi_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (take) rd_ptr <= next_ptr(rd_ptr);
            case ({push, take})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;  // both or neither
            endcase
        end
    end

endmodule

/* logic/burst_scheduler.sv */
`timescale 1ns/1ns
`include "frame_writer_params.svh"

module burst_scheduler
    import frame_writer_pkg::*;
(
    input  logic       M_AXI_ACLK,
    input  logic       sync_axi_rst,
    input  fifo_cnt_t  count,
    output burst_req_t req,
    output logic       req_valid,
    input  logic       req_ready,
    output buf_index_t frame_index
);

    burst_cnt_t burst_cnt;
    axi_addr_t  frame_base;   // start of the current buffer
    axi_addr_t  burst_off;    // offset of the next burst in that buffer
    logic       accept;
    logic       last_burst;
    logic       last_buf;

    // a burst goes out only once all of its beats sit in the fifo.
    // the master pops only outside idle, so while it waits in idle
    // the count can only grow and a raised request holds
    assign req_valid = (count >= fifo_cnt_t'(`BURST_LEN));
    assign req.addr  = frame_base + burst_off;

    assign accept     = req_valid & req_ready;
    assign last_burst = (burst_cnt == burst_cnt_t'(`BURSTS_PER_FRAME - 1));
    assign last_buf   = (frame_index == buf_index_t'(`BUF_NUM - 1));

    // position inside the frame
    always_ff @(posedge M_AXI_ACLK) begin
        if (!sync_axi_rst) begin
            burst_cnt <= '0;
            burst_off <= '0;
        end else if (accept) begin
            if (last_burst) begin
                burst_cnt <= '0;
                burst_off <= '0;
            end else begin
                burst_cnt <= burst_cnt + 1'b1;
                burst_off <= burst_off + axi_addr_t'(`BURST_BYTES);
            end
        end
    end

    // buffer rotation once the final burst of a frame is taken
    always_ff @(posedge M_AXI_ACLK) begin
        if (!sync_axi_rst) begin
            frame_index <= '0;
            frame_base  <= axi_addr_t'(`WR_BASE_ADDR);
        end else if (accept && last_burst) begin
            if (last_buf) begin
                frame_index <= '0;
                frame_base  <= axi_addr_t'(`WR_BASE_ADDR);  // back to buffer 0
            end else begin
                frame_index <= frame_index + 1'b1;
                frame_base  <= frame_base + axi_addr_t'(`FRAME_BYTES);
            end
        end
    end

endmodule

/* logic/axi_write_master.sv */
`timescale 1ns/1ns
`include "frame_writer_params.svh"

module axi_write_master
    import frame_writer_pkg::*;
(
    input  logic       M_AXI_ACLK,
    input  logic       sync_axi_rst,
    input  burst_req_t req,
    input  logic       req_valid,
    output logic       req_ready,
    input  axi_data_t  head,
    output logic       pop,
    output aw_req_t    m_axi_aw,
    output logic       m_axi_awvalid,
    input  logic       m_axi_awready,
    output w_beat_t    m_axi_w,
    output logic       m_axi_wvalid,
    input  logic       m_axi_wready,
    input  logic [1:0] m_axi_bresp,
    input  logic       m_axi_bvalid,
    output logic       m_axi_bready
);

    wr_state_e state;
    axi_addr_t aw_addr;
    beat_cnt_t beat_cnt;
    logic      bready_q;
    logic      aw_hs;
    logic      w_hs;
    logic      last_beat;

    assign req_ready = (state == WR_IDLE);

    assign m_axi_awvalid = (state == WR_ADDR);
    assign m_axi_aw.addr = aw_addr;
    assign aw_hs         = m_axi_awvalid & m_axi_awready;

    assign last_beat     = (beat_cnt == beat_cnt_t'(`BURST_LEN - 1));
    assign m_axi_wvalid  = (state == WR_DATA);
    assign m_axi_w.data  = head;       // fifo head is the current beat
    assign m_axi_w.last  = last_beat;
    assign w_hs          = m_axi_wvalid & m_axi_wready;
    assign pop           = w_hs;

    // one burst at a time
    always_ff @(posedge M_AXI_ACLK) begin
        if (!sync_axi_rst) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: if (req_valid) state <= WR_ADDR;
                WR_ADDR: if (aw_hs) state <= WR_DATA;
                WR_DATA: if (w_hs && last_beat) state <= WR_IDLE;
                default: state <= WR_IDLE;
            endcase
        end
    end

    // address captured when the request is taken
    always_ff @(posedge M_AXI_ACLK) begin
        if (req_ready && req_valid) begin
            aw_addr <= req.addr;
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (!sync_axi_rst) begin
            beat_cnt <= '0;
        end else if (aw_hs) begin
            beat_cnt <= '0;
        end else if (w_hs) begin
            beat_cnt <= beat_cnt + 1'b1;  // wraps after the last beat
        end
    end

    // responses are always taken, bresp and bvalid are not looked at
    always_ff @(posedge M_AXI_ACLK) begin
        if (!sync_axi_rst) begin
            bready_q <= 1'b0;
        end else begin
            bready_q <= 1'b1;
        end
    end

    assign m_axi_bready = bready_q;

endmodule

/* logic/frame_writer.sv */
`timescale 1ns/1ns

module frame_writer
    import frame_writer_pkg::*;
(
    input  logic       M_AXI_ACLK,
    input  logic       sync_axi_rst,
    // pixel stream
    input  axi_data_t  pix_data,
    input  logic       pix_valid,
    output logic       pix_ready,
    // AXI4 write channels
    output aw_req_t    m_axi_aw,
    output logic       m_axi_awvalid,
    input  logic       m_axi_awready,
    output w_beat_t    m_axi_w,
    output logic       m_axi_wvalid,
    input  logic       m_axi_wready,
    input  logic [1:0] m_axi_bresp,
    input  logic       m_axi_bvalid,
    output logic       m_axi_bready,
    output buf_index_t frame_index   // buffer being written
);

    axi_data_t  head;
    logic       pop;
    fifo_cnt_t  count;
    burst_req_t req;
    logic       req_valid;
    logic       req_ready;

    pixel_fifo i_pixel_fifo (
        .M_AXI_ACLK   (M_AXI_ACLK),
        .sync_axi_rst (sync_axi_rst),
        .pix_data     (pix_data),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .head         (head),
        .pop          (pop),
        .count        (count)
    );

    burst_scheduler i_burst_scheduler (
        .M_AXI_ACLK   (M_AXI_ACLK),
        .sync_axi_rst (sync_axi_rst),
        .count        (count),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .frame_index  (frame_index)
    );

    axi_write_master i_axi_write_master (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .sync_axi_rst  (sync_axi_rst),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .head          (head),
        .pop           (pop),
        .m_axi_aw      (m_axi_aw),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready),
        .m_axi_w       (m_axi_w),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_wready  (m_axi_wready),
        .m_axi_bresp   (m_axi_bresp),
        .m_axi_bvalid  (m_axi_bvalid),
        .m_axi_bready  (m_axi_bready)
    );

endmodule

/* testbench/frame_write_checker.sv */
`timescale 1ns/1ns
`include "frame_writer_params.svh"

module frame_write_checker
    import frame_writer_pkg::*;
(
    input  logic       M_AXI_ACLK,
    input  logic       sync_axi_rst,
    input  axi_data_t  pix_data,
    input  logic       pix_valid,
    input  logic       pix_ready,
    input  aw_req_t    m_axi_aw,
    input  logic       m_axi_awvalid,
    input  logic       m_axi_awready,
    input  w_beat_t    m_axi_w,
    input  logic       m_axi_wvalid,
    input  logic       m_axi_wready,
    input  logic       m_axi_bready,
    input  buf_index_t frame_index,
    output int         error_count,
    output int         aw_count,
    output int         bursts_done
);

    axi_data_t  accepted_q[$];   // pixel words in order of acceptance
    int         beat_in_burst;
    int         outstanding;     // words held by the fifo
    int         cycles_out;      // rising edges since reset release
    logic       burst_open;
    logic       frame_watch;
    buf_index_t exp_frame;

    // address of the nth burst since reset
    function automatic axi_addr_t expected_addr(input int n);
        int buf_n;
        int burst_n;
        buf_n   = (n / `BURSTS_PER_FRAME) % `BUF_NUM;
        burst_n = n % `BURSTS_PER_FRAME;
        return axi_addr_t'(`WR_BASE_ADDR + buf_n * `FRAME_BYTES + burst_n * `BURST_BYTES);
    endfunction

    task automatic flag_error(input string msg);
        error_count++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    task automatic check_w_beat();
        axi_data_t exp_word;
        if (accepted_q.size() == 0) begin
            flag_error("W beat with no pixel word left to write");
        end else begin
            exp_word = accepted_q.pop_front();
            if (m_axi_w.data !== exp_word) begin
                flag_error($sformatf("W data %h, expected %h", m_axi_w.data, exp_word));
            end
        end
        if (!burst_open) begin
            flag_error($sformatf("W beat outside a burst, %0d AW seen", aw_count));
        end else begin
            if (m_axi_w.last !== (beat_in_burst == `BURST_LEN - 1)) begin
                flag_error($sformatf("wlast %b on beat %0d", m_axi_w.last, beat_in_burst));
            end
            beat_in_burst++;
            if (beat_in_burst == `BURST_LEN) begin
                burst_open = 1'b0;
                bursts_done++;
            end
        end
        outstanding--;
    endtask

    task automatic check_aw();
        if (burst_open) begin
            flag_error($sformatf("AW %0d before burst %0d ended", aw_count, aw_count - 1));
        end
        if (m_axi_aw.addr !== expected_addr(aw_count)) begin
            flag_error($sformatf("AW %0d address %h, expected %h",
                                 aw_count, m_axi_aw.addr, expected_addr(aw_count)));
        end
        frame_watch = 1'b0;
        if (aw_count % `BURSTS_PER_FRAME == `BURSTS_PER_FRAME - 1) begin
            exp_frame   = buf_index_t'(((aw_count + 1) / `BURSTS_PER_FRAME) % `BUF_NUM);
            frame_watch = 1'b1;   // checked from the next edge
        end
        burst_open    = 1'b1;
        beat_in_burst = 0;
        aw_count++;
    endtask

    always @(posedge M_AXI_ACLK) begin
        if (!sync_axi_rst) begin
            accepted_q.delete();
            error_count = 0;
            aw_count    = 0;
            bursts_done = 0;
            outstanding = 0;
            cycles_out  = 0;
            burst_open  = 1'b0;
            frame_watch = 1'b1;
            exp_frame   = '0;
        end else begin
            cycles_out++;
            if (cycles_out <= 2 && (m_axi_awvalid || m_axi_wvalid)) begin
                flag_error("awvalid or wvalid high right after reset");
            end
            if (cycles_out >= 2 && m_axi_bready !== 1'b1) begin
                flag_error("bready low after reset");
            end
            if (pix_ready !== (outstanding < `FIFO_DEPTH)) begin
                flag_error($sformatf("pix_ready %b with %0d words queued", pix_ready, outstanding));
            end
            if (frame_watch && frame_index !== exp_frame) begin
                flag_error($sformatf("frame_index %0d, expected %0d", frame_index, exp_frame));
            end
            if (m_axi_wvalid && m_axi_wready) check_w_beat();
            if (m_axi_awvalid && m_axi_awready) check_aw();
            if (pix_valid && pix_ready) begin   // after the W check, a word cannot leave same cycle
                accepted_q.push_back(pix_data);
                outstanding++;
            end
        end
    end

endmodule

/* testbench/tb_frame_writer.sv */
`timescale 1ns/1ns
`include "frame_writer_params.svh"

module tb_frame_writer
    import frame_writer_pkg::*;
();

    localparam int FRAMES         = 7;
    localparam int FRAME_WORDS    = `BURSTS_PER_FRAME * `BURST_LEN;
    localparam int TOTAL_BURSTS   = FRAMES * `BURSTS_PER_FRAME;
    localparam int TOTAL_WORDS    = FRAMES * FRAME_WORDS;
    localparam int TIMEOUT_CYCLES = 20000;

    logic       M_AXI_ACLK;
    logic       sync_axi_rst;
    axi_data_t  pix_data;
    logic       pix_valid;
    logic       pix_ready;
    aw_req_t    m_axi_aw;
    logic       m_axi_awvalid;
    logic       m_axi_awready;
    w_beat_t    m_axi_w;
    logic       m_axi_wvalid;
    logic       m_axi_wready;
    logic [1:0] m_axi_bresp;
    logic       m_axi_bvalid;
    logic       m_axi_bready;
    buf_index_t frame_index;

    int   error_count;
    int   aw_count;
    int   bursts_done;

    int   words_sent;    // pixel words taken by the DUT
    logic ready_seen;    // pix_ready during the cycle now ending
    int   b_pending;     // bursts still owed a write response
    logic b_fire;
    logic w_last_fire;
    logic timed_out;
    logic aw_mismatch;

    frame_writer i_dut (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .sync_axi_rst  (sync_axi_rst),
        .pix_data      (pix_data),
        .pix_valid     (pix_valid),
        .pix_ready     (pix_ready),
        .m_axi_aw      (m_axi_aw),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready),
        .m_axi_w       (m_axi_w),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_wready  (m_axi_wready),
        .m_axi_bresp   (m_axi_bresp),
        .m_axi_bvalid  (m_axi_bvalid),
        .m_axi_bready  (m_axi_bready),
        .frame_index   (frame_index)
    );

    frame_write_checker i_checker (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .sync_axi_rst  (sync_axi_rst),
        .pix_data      (pix_data),
        .pix_valid     (pix_valid),
        .pix_ready     (pix_ready),
        .m_axi_aw      (m_axi_aw),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready),
        .m_axi_w       (m_axi_w),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_wready  (m_axi_wready),
        .m_axi_bready  (m_axi_bready),
        .frame_index   (frame_index),
        .error_count   (error_count),
        .aw_count      (aw_count),
        .bursts_done   (bursts_done)
    );

    // incrementing low half, inverted copy on top
    function automatic axi_data_t pixel_word(input int n);
        return {~32'(n), 32'(n)};
    endfunction

    task automatic drive_pixels();
        if (pix_valid && ready_seen) begin   // taken at the last rising edge
            words_sent++;
            pix_data = pixel_word(words_sent);
        end
        if (words_sent < TOTAL_WORDS) begin
            pix_valid = ($urandom % 4) != 0;
        end else begin
            pix_valid = 1'b0;
        end
        ready_seen = pix_ready;  // stable until the next rising edge
    endtask

    task automatic drive_slave();
        if (b_fire) b_pending--;
        if (w_last_fire) b_pending++;
        m_axi_bvalid  = (b_pending != 0);
        m_axi_awready = ($urandom % 2) == 0;
        // frames 2 and 3 see heavy W stalls so the fifo runs full
        if (words_sent >= 2 * FRAME_WORDS && words_sent < 4 * FRAME_WORDS) begin
            m_axi_wready = ($urandom % 4) == 0;
        end else begin
            m_axi_wready = ($urandom % 4) != 0;
        end
        b_fire      = m_axi_bvalid && m_axi_bready;
        w_last_fire = m_axi_wvalid && m_axi_wready && m_axi_w.last;
    endtask

    initial begin
        M_AXI_ACLK = 1'b0;
        forever #4 M_AXI_ACLK = ~M_AXI_ACLK;
    end

    initial begin : main
        int wait_cycles;
        void'($urandom(32'ha429));
        sync_axi_rst  = 1'b0;
        pix_data      = pixel_word(0);
        pix_valid     = 1'b0;
        m_axi_awready = 1'b0;
        m_axi_wready  = 1'b0;
        m_axi_bresp   = 2'b00;   // always OKAY
        m_axi_bvalid  = 1'b0;
        words_sent    = 0;
        ready_seen    = 1'b0;
        b_pending     = 0;
        b_fire        = 1'b0;
        w_last_fire   = 1'b0;
        repeat (16) @(negedge M_AXI_ACLK);
        sync_axi_rst = 1'b1;
        wait_cycles  = 0;
        while ((bursts_done < TOTAL_BURSTS || b_pending != 0) && wait_cycles < TIMEOUT_CYCLES) begin
            @(negedge M_AXI_ACLK);
            drive_pixels();
            drive_slave();
            wait_cycles++;
        end
        timed_out = (bursts_done < TOTAL_BURSTS || b_pending != 0);
        if (timed_out) begin
            $display("timeout after %0d cycles: %0d of %0d bursts done, %0d responses open",
                     wait_cycles, bursts_done, TOTAL_BURSTS, b_pending);
        end
        aw_mismatch = (aw_count != TOTAL_BURSTS);
        if (aw_mismatch) begin
            $display("%0d AW handshakes seen where %0d bursts were sent",
                     aw_count, TOTAL_BURSTS);
        end
        $display("bursts %0d of %0d, aw %0d, words sent %0d, errors %0d",
                 bursts_done, TOTAL_BURSTS, aw_count, words_sent, error_count);
        if (!timed_out && !aw_mismatch && error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+logic
logic/frame_writer_pkg.sv
logic/pixel_fifo.sv
logic/burst_scheduler.sv
logic/axi_write_master.sv
logic/frame_writer.sv
testbench/frame_write_checker.sv
testbench/tb_frame_writer.sv

/* Bender.yml */
package:
  name: frame_writer

export_include_dirs:
  - logic

sources:
  - logic/frame_writer_pkg.sv
  - logic/pixel_fifo.sv
  - logic/burst_scheduler.sv
  - logic/axi_write_master.sv
  - logic/frame_writer.sv
  - target: test
    files:
      - testbench/frame_write_checker.sv
      - testbench/tb_frame_writer.sv
